//--- dv/clockGen.sv
// Testbench clock and reset source, 40 ns ctrl_wen period with reset held for the first 10 cycles
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic ctrl_wen,
    output logic reset
);

    initial
    begin
        ctrl_wen = 1'b0;
        forever #20 ctrl_wen = ~ctrl_wen;   // 40 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (10) @(posedge ctrl_wen);
        reset <= 1'b0;                      // Released on a rising edge
    end

endmodule

`default_nettype wire

//--- dv/mdioPatterns.txt
// Columns, hex: kind phyAddr regAddr ctrl(mask,bit) value
// Kinds: 1 read, 2 write, 3 link control, 4 log dump, 5 status, 6 preamble breaks
5 00 00 0 0000
1 01 00 0 0000
1 01 01 0 0000
1 01 02 0 0000
1 01 03 0 0000
1 01 04 0 0000
1 01 05 0 0000
1 01 06 0 0000
1 01 07 0 0000
1 01 08 0 0000
1 01 09 0 0000
1 01 0a 0 0000
1 01 0b 0 0000
1 01 0c 0 0000
1 01 0d 0 0000
1 01 0e 0 0000
1 01 0f 0 0000
3 00 00 3 0000 // Link up
1 01 01 0 0000
3 00 00 0 0000 // Mask clear, link must stay up
1 01 01 0 0000
3 00 00 2 0000 // Link down
1 01 01 0 0000
1 08 02 0 0040
1 08 00 0 0040
1 03 00 0 0000
1 01 14 0 0000 // Unsupported register 20
5 00 00 0 0000
2 01 00 0 1234
1 01 00 0 0000
4 00 00 0 0000
6 00 00 0 0003
5 00 00 0 0000
6 00 00 0 000e // Counter wraps to 1
5 00 00 0 0000

//--- dv/virtualPhyTb.sv
// Testbench for the virtual PHY, replays dv/mdioPatterns.txt over the MDIO, control and debug ports
`timescale 1ns/1ps
`default_nettype none

module virtualPhyTb;
    import mdioPkg::*;

    logic        ctrl_wen;
    logic        reset;
    logic        mdc;
    logic        mdioFromHost;
    logic        mdioHostTri;
    logic        mdioToHost;
    logic        ctrlWrite;
    logic        linkOnMask;
    logic        linkOnBit;
    logic [15:0] debugAddr;
    logic [31:0] debugData;

    logic [15:0] patterns [5 * 64];      // Five columns per line
    int          patternCount;
    integer      seed;                   // Idle gap generator

    // Reference model of the PHY state
    logic        linkModel;
    mdioWord     logModel [LOG_DEPTH];
    logic [3:0]  logIdx;
    mdioWord     lastFrame;
    logic [4:0]  lastUnsup;
    logic [3:0]  errCount;

    clockGen clocks (.ctrl_wen(ctrl_wen), .reset(reset));

    virtualPhy dut (
        .ctrl_wen     (ctrl_wen),
        .reset        (reset),
        .mdc          (mdc),
        .mdioFromHost (mdioFromHost),
        .mdioHostTri  (mdioHostTri),
        .mdioToHost   (mdioToHost),
        .ctrlWrite    (ctrlWrite),
        .linkOnMask   (linkOnMask),
        .linkOnBit    (linkOnBit),
        .debugAddr    (debugAddr),
        .debugData    (debugData)
    );

    bind virtualPhy virtualPhyChecker phyChecker (
        .ctrl_wen    (ctrl_wen),
        .reset       (reset),
        .frameStrobe (frameStrobe),
        .rxState     (receiver.state),
        .mdioHostTri (mdioHostTri),
        .bitCount    (receiver.bitCount),
        .mdioToHost  (mdioToHost),
        .logPtr      (log.logPtr)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkReply(input logic [15:0] got, input logic [15:0] expected,
                              input string what);
        if (got !== expected)
        begin
            abortRun($sformatf("** Error at %0d ns: %s gave %h, expected %h",
                               $time, what, got, expected));
        end
    endtask

    task automatic checkDebug(input mdioWord got, input mdioWord expected, input string what);
        if (got.raw !== expected.raw)
        begin
            abortRun($sformatf("** Error at %0d ns: %s gave %h, expected %h",
                               $time, what, got.raw, expected.raw));
        end
    endtask

    // One mdc period, 4 cycles low then 4 high, PHY line sampled just before the rise
    task automatic sendBit(input logic value, input logic hostTri, output logic seen);
        mdc          <= 1'b0;
        mdioFromHost <= value;
        mdioHostTri  <= hostTri;
        repeat (3) @(posedge ctrl_wen);
        @(negedge ctrl_wen);
        seen = mdioToHost;
        @(posedge ctrl_wen);
        mdc <= 1'b1;
        repeat (4) @(posedge ctrl_wen);
    endtask

    task automatic idleGap();
        int gap;
        gap = 2 + ($unsigned($random(seed)) % 8);
        mdc          <= 1'b0;
        mdioFromHost <= 1'b0;
        mdioHostTri  <= 1'b1;            // Host releases the line
        repeat (gap) @(posedge ctrl_wen);
    endtask

    task automatic sendFrame(input mdioWord word, output logic [15:0] reply);
        logic isRead;
        logic seen;
        isRead = (word.frame.opcode == OP_READ);
        reply  = 16'h0000;
        for (int i = 0; i < PREAMBLE_BITS; i++)
        begin
            sendBit(1'b1, 1'b0, seen);
        end
        for (int i = 0; i < FRAME_BITS; i++)
        begin
            sendBit(word.raw[31 - i], isRead && (i >= HEADER_BITS), seen);
            if (i >= 16)
            begin
                reply[31 - i] = seen;    // Reply MSB first
            end
        end
        idleGap();
    endtask

    // Each break is two ones and a zero, never a full preamble
    task automatic breakPreamble(input int breaks);
        logic seen;
        for (int b = 0; b < breaks; b++)
        begin
            sendBit(1'b1, 1'b0, seen);
            sendBit(1'b1, 1'b0, seen);
            sendBit(1'b0, 1'b0, seen);
            errCount = errCount + 4'd1;  // Wraps like the DUT counter
        end
        idleGap();
    endtask

    task automatic debugRead(input logic [15:0] addr, output mdioWord data);
        debugAddr <= addr;
        @(negedge ctrl_wen);
        data = debugData;
        @(posedge ctrl_wen);
    endtask

    function automatic logic [15:0] standardValue(input logic [3:0] regNum);
        logic [15:0] value;
        value = REG_RESET_VALUE[regNum];
        if (regNum == 4'd1)
        begin
            value[LINK_BIT_POSITION] = linkModel;  // Live link bit in BMSR
        end
        return value;
    endfunction

    function automatic mdioWord buildFrame(input logic [1:0] opcode, input logic [4:0] phy,
                                           input logic [4:0] regNum, input logic [15:0] data);
        mdioWord word;
        word.frame.start      = START_PATTERN;
        word.frame.opcode     = opcode;
        word.frame.phyAddr    = phy;
        word.frame.regAddr    = regNum;
        word.frame.turnaround = 2'b10;
        word.frame.data       = data;
        return word;
    endfunction

    function automatic void recordFrame(input mdioWord word);
        logModel[logIdx] = word;
        logIdx           = logIdx + 4'd1;
        lastFrame        = word;
        if ((word.frame.phyAddr == PHY_ADDR_MAIN) && word.frame.regAddr[4])
        begin
            lastUnsup = word.frame.regAddr;
        end
    endfunction

    function automatic mdioWord statusExpected();
        mdioWord status;
        status.raw = {3'd0, lastUnsup, 3'd0, lastFrame.frame.phyAddr,
                      3'd0, lastFrame.frame.regAddr, errCount, 1'b0,
                      (lastFrame.frame.start == START_PATTERN), lastFrame.frame.opcode};
        return status;
    endfunction

    initial
    begin
        real limit;
        wait (patternCount > 0);
        limit = patternCount * 64 * 8 * 40.0 + 100000.0;  // Bits, mdc cycles, period, margin
        #(limit);
        abortRun("Timeout: the pattern run did not finish in time");
    end

    initial
    begin
        int          base;
        logic [15:0] kind;
        logic [4:0]  phy;
        logic [4:0]  regNum;
        logic [1:0]  ctrl;
        logic [15:0] value;
        logic [15:0] got16;
        logic [15:0] expected16;
        mdioWord     word;
        mdioWord     gotWord;
        mdc          = 1'b0;
        mdioFromHost = 1'b0;
        mdioHostTri  = 1'b1;
        ctrlWrite    = 1'b0;
        linkOnMask   = 1'b0;
        linkOnBit    = 1'b0;
        debugAddr    = 16'h0000;
        seed         = 32'hc3f9;
        linkModel    = 1'b0;
        logIdx       = 4'd0;
        lastFrame    = '0;
        lastUnsup    = 5'd0;
        errCount     = 4'd0;
        patternCount = 0;
        for (int i = 0; i < LOG_DEPTH; i++)
        begin
            logModel[i] = '0;
        end
        for (int i = 0; i < $size(patterns); i++)
        begin
            patterns[i] = 16'h0000;      // Kind 0 marks the end
        end
        $readmemh("dv/mdioPatterns.txt", patterns);
        while ((patternCount * 5 < $size(patterns)) && (patterns[patternCount * 5] != 16'h0))
        begin
            patternCount++;
        end
        if (patternCount == 0)
        begin
            abortRun("No patterns were read from dv/mdioPatterns.txt");
        end

        @(posedge ctrl_wen);
        while (reset)
        begin
            @(posedge ctrl_wen);
        end
        repeat (2) @(posedge ctrl_wen);

        for (int p = 0; p < patternCount; p++)
        begin
            base   = p * 5;
            kind   = patterns[base];
            phy    = patterns[base + 1][4:0];
            regNum = patterns[base + 2][4:0];
            ctrl   = patterns[base + 3][1:0];
            value  = patterns[base + 4];
            case (kind)
                16'h1:
                begin
                    if ((phy == PHY_ADDR_MAIN) && !regNum[4])
                    begin
                        expected16 = standardValue(regNum[3:0]);
                    end
                    else
                    begin
                        expected16 = value;   // Identity or zero from the file
                    end
                    word = buildFrame(OP_READ, phy, regNum, 16'h0000);
                    sendFrame(word, got16);
                    checkReply(got16, expected16,
                               $sformatf("MDIO read of PHY %0d register %0d", phy, regNum));
                    word.frame.data = expected16;  // Log holds the driven reply
                    recordFrame(word);
                end
                16'h2:
                begin
                    word = buildFrame(OP_WRITE, phy, regNum, value);
                    sendFrame(word, got16);
                    recordFrame(word);
                end
                16'h3:
                begin
                    ctrlWrite  <= 1'b1;
                    linkOnMask <= ctrl[1];
                    linkOnBit  <= ctrl[0];
                    @(posedge ctrl_wen);
                    ctrlWrite  <= 1'b0;
                    linkOnMask <= 1'b0;
                    linkOnBit  <= 1'b0;
                    @(posedge ctrl_wen);
                    if (ctrl[1])
                    begin
                        linkModel = ctrl[0];
                    end
                end
                16'h4:
                begin
                    for (int k = 0; k < LOG_DEPTH; k++)
                    begin
                        debugRead({8'h00, DEBUG_LOG_PAGE, 4'(k)}, gotWord);
                        checkDebug(gotWord, logModel[k], $sformatf("log entry %0d", k));
                    end
                end
                16'h5:
                begin
                    debugRead({8'h00, DEBUG_STATUS_ADDR}, gotWord);
                    checkDebug(gotWord, statusExpected(), "debug status word");
                    debugRead({8'h01, DEBUG_STATUS_ADDR}, gotWord);
                    checkDebug(gotWord, '0, "unmapped debug address");
                end
                16'h6:
                begin
                    breakPreamble(int'(value));
                end
                default:
                begin
                    abortRun($sformatf("Pattern %0d has an unknown kind %h", p, kind));
                end
            endcase
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/virtualPhy_checker.sv
// Concurrent checks on the receiver FSM, the frame log pointer and the reply line, bound into virtualPhy
`timescale 1ns/1ps
`default_nettype none

module virtualPhyChecker (
    input logic       ctrl_wen,
    input logic       reset,
    input logic       frameStrobe,
    input logic [1:0] rxState,       // Receiver FSM state
    input logic       mdioHostTri,   // Host has released the line
    input logic [4:0] bitCount,
    input logic       mdioToHost,
    input logic [3:0] logPtr         // Next log entry
);
    import mdioPkg::*;

    // Done is reached only after bit 31, counter wrapped
    strobeFromDone: assert property (@(posedge ctrl_wen) disable iff (reset)
        frameStrobe |-> ($past(rxState) == ST_RECEIVE) && (bitCount == 5'd0))
        else $error("frameStrobe raised without a completed frame");

    // One step per logged frame, wraps at 16
    pointerStep: assert property (@(posedge ctrl_wen) disable iff (reset)
        frameStrobe |=> logPtr == $past(logPtr) + 4'd1)
        else $error("log pointer did not advance by one on a frame strobe");

    pointerHold: assert property (@(posedge ctrl_wen) disable iff (reset)
        !frameStrobe |=> $stable(logPtr))
        else $error("log pointer moved without a frame strobe");

    // PHY drives only in data bits while the host line is released
    replyQuiet: assert property (@(posedge ctrl_wen) disable iff (reset)
        !(mdioHostTri && (rxState == ST_RECEIVE) && bitCount[4]) |-> !mdioToHost)
        else $error("mdioToHost high outside the reply window");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module virtualPhyTb &&
./obj_dir/VvirtualPhyTb | tee /dev/stderr | grep -q "Everything OK" ||
{ echo "virtualPhy simulation did not pass"; exit 1; }

//--- source/frameLog.sv
// Frame log: keeps the last 16 MDIO frames and a status word, read through the debug port
`timescale 1ns/1ps
`default_nettype none

module frameLog (
    input  logic               ctrl_wen,
    input  logic               reset,
    input  logic               frameStrobe,
    input  mdioPkg::frameEvent frameIn,
    input  logic               preambleError,
    input  logic [15:0]        debugAddr,
    output logic [31:0]        debugData
);
    import mdioPkg::*;

    logic [31:0] logMem [LOG_DEPTH];  // Raw frame words
    logic [3:0]  logPtr;              // Next entry to write
    logic [4:0]  lastUnsupported;     // Register of last unsupported access
    logic [3:0]  errorCount;          // Preamble breaks, wraps at 16
    mdioWord     lastFrame;
    logic        startValid;
    logic [31:0] statusWord;

    always_ff @(posedge ctrl_wen)
    begin
        if (reset)
        begin
            for (int i = 0; i < LOG_DEPTH; i++)
            begin
                logMem[i] <= 32'd0;
            end
            logPtr          <= 4'd0;
            lastUnsupported <= 5'd0;
            errorCount      <= 4'd0;
            lastFrame.raw   <= 32'd0;
        end
        else
        begin
            if (frameStrobe)
            begin
                logMem[logPtr] <= frameIn.frame.raw; // Oldest entry overwritten
                logPtr         <= logPtr + 4'd1;
                lastFrame      <= frameIn.frame;
                if (frameIn.isUnsupported)
                begin
                    lastUnsupported <= frameIn.frame.frame.regAddr;
                end
            end
            if (preambleError)
            begin
                errorCount <= errorCount + 4'd1;
            end
        end
    end

    assign startValid = (lastFrame.frame.start == START_PATTERN);
    assign statusWord = {3'd0, lastUnsupported,
                         3'd0, lastFrame.frame.phyAddr,
                         3'd0, lastFrame.frame.regAddr,
                         errorCount, 1'b0, startValid, lastFrame.frame.opcode};

    // Full address decode, page b first
    always_comb
    begin
        if (debugAddr[15:4] == {8'h00, DEBUG_LOG_PAGE})
        begin
            debugData = logMem[debugAddr[3:0]];
        end
        else if (debugAddr == {8'h00, DEBUG_STATUS_ADDR})
        begin
            debugData = statusWord;
        end
        else
        begin
            debugData = 32'd0;
        end
    end

endmodule

`default_nettype wire

//--- source/mdioFrameReceiver.sv
// MDIO frame receiver: samples mdc in the ctrl_wen domain, finds the preamble and shifts in frames
`timescale 1ns/1ps
`default_nettype none

module mdioFrameReceiver (
    input  logic               ctrl_wen,
    input  logic               reset,
    input  logic               mdc,
    input  logic               mdioFromHost,
    input  logic               mdioHostTri,
    input  logic [15:0]        replyWord,
    output logic               mdioToHost,
    output logic               headerStrobe,
    output mdioPkg::mdioHeader header,
    output logic               frameStrobe,
    output mdioPkg::frameEvent frameOut,
    output logic               preambleError
);
    import mdioPkg::*;

    logic [1:0] mdcSync;          // Two-flop synchroniser
    logic       mdcLast;          // Previous synchronised level
    logic       mdcRise;          // One bit boundary
    logic [1:0] state;
    logic [4:0] bitCount;         // Preamble count, then frame bit number
    logic       readFrame;        // Current frame is a read
    logic       replyWindow;      // PHY owns the data bits
    logic       sampledBit;       // Bit recorded into the frame
    logic       headerDone;       // Last header bit on this edge
    logic       nextIsRead;
    mdioWord    frameReg;
    mdioWord    frameNext;

    assign mdcRise = mdcSync[1] & ~mdcLast;

    always_ff @(posedge ctrl_wen)
    begin
        if (reset)
        begin
            mdcSync <= 2'b00;
            mdcLast <= 1'b0;
        end
        else
        begin
            mdcSync <= {mdcSync[0], mdc};
            mdcLast <= mdcSync[1];
        end
    end

    // Reply bit 15 is driven during frame bit 16
    assign replyWindow = (state == ST_RECEIVE) && readFrame && bitCount[4];
    assign mdioToHost  = replyWindow ? replyWord[~bitCount[3:0]] : 1'b0;

    // Read frames log what the PHY drove, not the host line
    assign sampledBit = replyWindow ? mdioToHost : mdioFromHost;

    always_comb
    begin
        frameNext = frameReg;
        frameNext.raw[~bitCount] = sampledBit;   // Bit n lands at 31-n
    end

    assign headerDone = (state == ST_RECEIVE) && mdcRise
                        && (bitCount == 5'(HEADER_BITS - 1));
    assign nextIsRead = (frameNext.frame.opcode == OP_READ);

    always_ff @(posedge ctrl_wen)
    begin
        if (reset)
        begin
            state         <= ST_SEARCH;
            bitCount      <= 5'd0;
            readFrame     <= 1'b0;
            headerStrobe  <= 1'b0;
            preambleError <= 1'b0;
        end
        else
        begin
            headerStrobe  <= headerDone;          // One-cycle pulses
            preambleError <= 1'b0;
            case (state)
                ST_SEARCH:
                begin
                    if (mdcRise)
                    begin
                        if (mdioHostTri)
                        begin
                            bitCount <= 5'd0;     // Host not driving
                        end
                        else if (mdioFromHost)
                        begin
                            bitCount <= bitCount + 5'd1;
                            if (bitCount == 5'(PREAMBLE_BITS - 1))
                            begin
                                state     <= ST_RECEIVE;
                                readFrame <= 1'b0;
                            end
                        end
                        else
                        begin
                            preambleError <= 1'b1; // Broken preamble
                            bitCount      <= 5'd0;
                        end
                    end
                end
                ST_RECEIVE:
                begin
                    if (mdcRise)
                    begin
                        bitCount <= bitCount + 5'd1; // Wraps to 0 after bit 31
                        if (headerDone)
                        begin
                            readFrame <= nextIsRead;
                        end
                        if (bitCount == 5'(FRAME_BITS - 1))
                        begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE:
                begin
                    state <= ST_SEARCH;           // Frame handed to log this cycle
                end
                default:
                begin
                    state <= ST_SEARCH;
                end
            endcase
        end
    end

    // Frame and header payload
    always_ff @(posedge ctrl_wen)
    begin
        if ((state == ST_RECEIVE) && mdcRise)
        begin
            frameReg <= frameNext;
        end
        if (headerDone)
        begin
            header.isRead  <= nextIsRead;
            header.phyAddr <= frameNext.frame.phyAddr;
            header.regAddr <= frameNext.frame.regAddr;
        end
    end

    assign frameStrobe             = (state == ST_DONE);
    assign frameOut.frame          = frameReg;
    assign frameOut.isUnsupported  = (frameReg.frame.phyAddr == PHY_ADDR_MAIN)
                                     && frameReg.frame.regAddr[4];

endmodule

`default_nettype wire

//--- source/mdioPkg.sv
// Shared MDIO frame layout, reply and log types, and PHY register constants for the virtual PHY
`default_nettype none

package mdioPkg;

    // Frame sizes from the clause-22 MDIO standard
    localparam int PREAMBLE_BITS = 32;                // Ones before the start pattern
    localparam int FRAME_BITS    = 32;                // Start through data
    localparam int HEADER_BITS   = 14;                // Start, opcode, PHY and register address

    localparam logic [1:0] OP_READ       = 2'b10;
    localparam logic [1:0] OP_WRITE      = 2'b01;
    localparam logic [1:0] START_PATTERN = 2'b01;

    localparam logic [4:0]  PHY_ADDR_MAIN = 5'd1;     // Standard register space
    localparam logic [4:0]  PHY_ADDR_AUX  = 5'd8;     // Identity-only address
    localparam logic [15:0] AUX_REPLY     = 16'h0040; // Fixed identity word

    localparam int         LOG_DEPTH         = 16;
    localparam logic [3:0] DEBUG_LOG_PAGE    = 4'hb;  // Page holding log entries
    localparam logic [7:0] DEBUG_STATUS_ADDR = 8'haf; // Status word address

    localparam int LINK_BIT_POSITION = 2;             // Link status bit in BMSR

    // Receiver FSM states
    localparam logic [1:0] ST_SEARCH  = 2'd0;         // Waiting for preamble
    localparam logic [1:0] ST_RECEIVE = 2'd1;         // Shifting frame bits
    localparam logic [1:0] ST_DONE    = 2'd2;         // Frame complete, one cycle

    // Standard register values, link bit cleared in register 1
    localparam logic [15:0] REG_RESET_VALUE [16] = '{
        16'h1040,                                     // BMCR, 1G and autoneg
        16'h0128,                                     // BMSR, autoneg complete
        16'h7e19,                                     // PHYID1
        16'hc010,                                     // PHYID2, model 1 rev 0
        16'h0801,                                     // ANAR, asymmetric pause
        16'h0c01,                                     // ANLPAR, partner pause
        16'h0000,                                     // ANER
        16'h0000,                                     // ANNPTR
        16'h0000,                                     // ANNPRR
        16'h0200,                                     // GBCR, advertise 1G full
        16'h7c00,                                     // GBSR, master
        16'h0000,                                     // Reserved
        16'h0000,                                     // Reserved
        16'h0000,                                     // MACR
        16'h0000,                                     // MAADR
        16'h2000                                      // GBESR, 1G full capable
    };

    // Frame as seen on the wire, first bit in the MSB
    typedef struct packed {
        logic [1:0]  start;
        logic [1:0]  opcode;
        logic [4:0]  phyAddr;
        logic [4:0]  regAddr;
        logic [1:0]  turnaround;
        logic [15:0] data;
    } mdioFrame;

    // Same 32 bits as fields or as a raw log word
    typedef union packed {
        mdioFrame    frame;
        logic [31:0] raw;
    } mdioWord;

    typedef struct packed {
        logic       isRead;
        logic [4:0] phyAddr;
        logic [4:0] regAddr;
    } mdioHeader;

    typedef struct packed {
        mdioWord frame;
        logic    isUnsupported;                       // Address 1, register 16 and up
    } frameEvent;

endpackage

`default_nettype wire

//--- source/phyRegisterFile.sv
// PHY register file: holds the link flag and answers each received header with a reply word
`timescale 1ns/1ps
`default_nettype none

module phyRegisterFile (
    input  logic               ctrl_wen,
    input  logic               reset,
    input  logic               ctrlWrite,
    input  logic               linkOnMask,
    input  logic               linkOnBit,
    input  logic               headerStrobe,
    input  mdioPkg::mdioHeader header,
    output logic [15:0]        replyWord
);
    import mdioPkg::*;

    logic        linkOn;             // Link state seen by the host driver
    mdioHeader   headerReg;          // Header of the frame in progress
    logic [15:0] regTable [16];      // Standard registers with live link bit
    logic        isStandard;         // Address 1, registers 0 to 15
    logic        isAux;

    // Masked control write, mask clear leaves link alone
    always_ff @(posedge ctrl_wen)
    begin
        if (reset)
        begin
            linkOn <= 1'b0;
        end
        else if (ctrlWrite && linkOnMask)
        begin
            linkOn <= linkOnBit;
        end
    end

    // Latch header on the strobe, reply held until next one
    always_ff @(posedge ctrl_wen)
    begin
        if (headerStrobe)
        begin
            headerReg <= header;
        end
    end

    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            regTable[i] = REG_RESET_VALUE[i];
        end
        regTable[1][LINK_BIT_POSITION] = linkOn; // BMSR link status
    end

    assign isAux      = (headerReg.phyAddr == PHY_ADDR_AUX);
    assign isStandard = (headerReg.phyAddr == PHY_ADDR_MAIN) && !headerReg.regAddr[4];

    // Writes get no reply
    always_comb
    begin
        if (!headerReg.isRead)
        begin
            replyWord = 16'h0000;
        end
        else if (isAux)
        begin
            replyWord = AUX_REPLY;           // Identity only
        end
        else if (isStandard)
        begin
            replyWord = regTable[headerReg.regAddr[3:0]];
        end
        else
        begin
            replyWord = 16'h0000;            // Unknown address or register
        end
    end

endmodule

`default_nettype wire

//--- source/virtualPhy.sv
// Virtual PHY top: wires the frame receiver, register file and frame log to the outside ports
`timescale 1ns/1ps
`default_nettype none

module virtualPhy (
    input  logic        ctrl_wen,
    input  logic        reset,
    input  logic        mdc,           // Management clock from MAC
    input  logic        mdioFromHost,
    input  logic        mdioHostTri,   // High while host releases the line
    output logic        mdioToHost,
    input  logic        ctrlWrite,
    input  logic        linkOnMask,
    input  logic        linkOnBit,
    input  logic [15:0] debugAddr,
    output logic [31:0] debugData
);
    import mdioPkg::*;

    logic        headerStrobe;
    mdioHeader   header;
    logic [15:0] replyWord;
    logic        frameStrobe;
    frameEvent   frameEvt;
    logic        preambleError;

    mdioFrameReceiver receiver (
        .ctrl_wen      (ctrl_wen),
        .reset         (reset),
        .mdc           (mdc),
        .mdioFromHost  (mdioFromHost),
        .mdioHostTri   (mdioHostTri),
        .replyWord     (replyWord),
        .mdioToHost    (mdioToHost),
        .headerStrobe  (headerStrobe),
        .header        (header),
        .frameStrobe   (frameStrobe),
        .frameOut      (frameEvt),
        .preambleError (preambleError)
    );

    phyRegisterFile registers (
        .ctrl_wen     (ctrl_wen),
        .reset        (reset),
        .ctrlWrite    (ctrlWrite),
        .linkOnMask   (linkOnMask),
        .linkOnBit    (linkOnBit),
        .headerStrobe (headerStrobe),
        .header       (header),
        .replyWord    (replyWord)
    );

    frameLog log (
        .ctrl_wen      (ctrl_wen),
        .reset         (reset),
        .frameStrobe   (frameStrobe),
        .frameIn       (frameEvt),
        .preambleError (preambleError),
        .debugAddr     (debugAddr),
        .debugData     (debugData)
    );

endmodule

`default_nettype wire

//--- verilog.f
source/mdioPkg.sv
source/mdioFrameReceiver.sv
source/phyRegisterFile.sv
source/frameLog.sv
source/virtualPhy.sv
dv/clockGen.sv
dv/virtualPhy_checker.sv
dv/virtualPhyTb.sv
